/* design/frame_pkg.sv */
package frame_pkg;

  ////////////////////////////////////////////////////////////
  // raster and pixel widths
  ////////////////////////////////////////////////////////////

  // horizontal raster count
  localparam int HCOUNT_W = 11;
  // vertical raster count
  localparam int VCOUNT_W = 10;

  // incoming pixel, red in the top byte, then green, then blue
  localparam int PIXEL_IN_W = 24;
  // stored pixel, one memory word
  localparam int PIXEL_BYTE_W = 8;

  ////////////////////////////////////////////////////////////
  // stored pixel, 3 red, 3 green, 2 blue
  ////////////////////////////////////////////////////////////

  // raw is the memory word
  // fields splits it into the three channels, msb first
  typedef union packed {
    logic [PIXEL_BYTE_W-1:0] raw;
    struct packed {
      logic [2:0] red;
      logic [2:0] green;
      logic [1:0] blue;
    } fields;
  } rgb332_u;

endpackage

/* design/uart_pkg.sv */
package uart_pkg;

  ////////////////////////////////////////////////////////////
  // serial frame
  ////////////////////////////////////////////////////////////

  // data bits per frame, sent lsb first
  localparam int UART_DATA_W = 8;
  // start bit, data bits, stop bit
  localparam int UART_FRAME_BITS = 10;

  ////////////////////////////////////////////////////////////
  // channel order of the sender
  ////////////////////////////////////////////////////////////

  // green goes out first, red last
  localparam logic [1:0] CH_GREEN = 2'd0;
  localparam logic [1:0] CH_BLUE  = 2'd1;
  localparam logic [1:0] CH_RED   = 2'd2;

endpackage

/* design/frame_ctrl.sv */
module frame_ctrl (
  input  logic clk,
  input  logic uart_reset,
  input  logic store,
  input  logic send,
  input  logic frame_start,
  input  logic frame_last,
  input  logic send_done,
  output logic capture_en,
  output logic send_en,
  output logic frame_ready,
  output logic sending
);

  // main controller, cut down to grab and send
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_ARMED,
    ST_CAPTURE,
    ST_READY,
    ST_SEND
  } state_e;

  state_e state_q;

  always_ff @(posedge clk) begin
    if (uart_reset) begin
      state_q <= ST_IDLE;
    end else begin
      case (state_q)
        // nothing stored yet
        ST_IDLE: begin
          if (store) state_q <= ST_ARMED;
        end
        // wait for the window origin
        ST_ARMED: begin
          // one pixel window starts and ends in the same cycle
          if (frame_last) state_q <= ST_READY;
          else if (frame_start) state_q <= ST_CAPTURE;
        end
        // writing the window, requests dropped
        ST_CAPTURE: begin
          if (frame_last) state_q <= ST_READY;
        end
        // frame held, send it or grab a new one
        ST_READY: begin
          if (send) state_q <= ST_SEND;
          else if (store) state_q <= ST_ARMED;
        end
        // back to ready so the frame can go out again
        ST_SEND: begin
          if (send_done) state_q <= ST_READY;
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // levels straight from the state
  assign capture_en  = (state_q == ST_ARMED) || (state_q == ST_CAPTURE);
  assign send_en     = (state_q == ST_SEND);
  // frame stays valid while it is being sent
  assign frame_ready = (state_q == ST_READY) || (state_q == ST_SEND);
  assign sending     = (state_q == ST_SEND);

endmodule

/* design/capture_window.sv */
module capture_window #(
  parameter int H_OFFSET = 2,
  parameter int V_OFFSET = 1,
  parameter int FRAME_WIDTH = 4,
  parameter int FRAME_HEIGHT = 3,
  localparam int ADDR_W = (FRAME_WIDTH * FRAME_HEIGHT > 1) ?
                          $clog2(FRAME_WIDTH * FRAME_HEIGHT) : 1
) (
  input  logic                            clk,
  input  logic                            uart_reset,
  input  logic                            capture_en,
  input  logic [frame_pkg::HCOUNT_W-1:0]  hcount,
  input  logic [frame_pkg::VCOUNT_W-1:0]  vcount,
  input  logic [frame_pkg::PIXEL_IN_W-1:0] pixel_in,
  output logic                            frame_start,
  output logic                            frame_last,
  output logic                            wr_en,
  output logic [ADDR_W-1:0]               wr_addr,
  output frame_pkg::rgb332_u              wr_data
);

  import frame_pkg::*;

  // window corners in raster count widths
  localparam logic [HCOUNT_W-1:0] H_FIRST = HCOUNT_W'(H_OFFSET);
  localparam logic [HCOUNT_W-1:0] H_LAST  = HCOUNT_W'(H_OFFSET + FRAME_WIDTH - 1);
  localparam logic [VCOUNT_W-1:0] V_FIRST = VCOUNT_W'(V_OFFSET);
  localparam logic [VCOUNT_W-1:0] V_LAST  = VCOUNT_W'(V_OFFSET + FRAME_HEIGHT - 1);

  logic              in_window;
  logic              at_origin;
  logic              at_last;
  // set from the origin until the last window pixel
  logic              active_q;
  logic [ADDR_W-1:0] addr_q;

  assign in_window = (hcount >= H_FIRST) && (hcount <= H_LAST) &&
                     (vcount >= V_FIRST) && (vcount <= V_LAST);
  assign at_origin = (hcount == H_FIRST) && (vcount == V_FIRST);
  assign at_last   = (hcount == H_LAST) && (vcount == V_LAST);

  // a capture never starts mid window
  assign frame_start = capture_en && at_origin && !active_q;
  assign wr_en       = capture_en && in_window && (active_q || at_origin);
  assign frame_last  = wr_en && at_last;

  // running address, restarts at the origin
  assign wr_addr = at_origin ? '0 : addr_q;

  always_ff @(posedge clk) begin
    if (uart_reset) begin
      active_q <= 1'b0;
      addr_q   <= '0;
    end else begin
      if (!capture_en || frame_last) active_q <= 1'b0;
      else if (frame_start) active_q <= 1'b1;
      if (wr_en) addr_q <= wr_addr + ADDR_W'(1);
    end
  end

  // keep the top bits of each channel
  always_comb begin
    wr_data.fields.red   = pixel_in[PIXEL_IN_W-1 -: 3];
    wr_data.fields.green = pixel_in[PIXEL_IN_W-1-PIXEL_BYTE_W -: 3];
    wr_data.fields.blue  = pixel_in[PIXEL_IN_W-1-2*PIXEL_BYTE_W -: 2];
  end

endmodule

/* design/frame_store.sv */
module frame_store #(
  parameter int FRAME_WIDTH = 4,
  parameter int FRAME_HEIGHT = 3,
  localparam int ADDR_W = (FRAME_WIDTH * FRAME_HEIGHT > 1) ?
                          $clog2(FRAME_WIDTH * FRAME_HEIGHT) : 1
) (
  input  logic               clk,
  input  logic               wr_en,
  input  logic [ADDR_W-1:0]  wr_addr,
  input  frame_pkg::rgb332_u wr_data,
  input  logic [ADDR_W-1:0]  rd_addr,
  output frame_pkg::rgb332_u rd_data
);

  import frame_pkg::*;

  // one word per window pixel
  localparam int DEPTH = FRAME_WIDTH * FRAME_HEIGHT;

  logic [PIXEL_BYTE_W-1:0] mem [DEPTH];

  // write port
  always_ff @(posedge clk) begin
    if (wr_en) mem[wr_addr] <= wr_data.raw;
  end

  // registered read, data one cycle after the address
  always_ff @(posedge clk) begin
    rd_data.raw <= mem[rd_addr];
  end

endmodule

/* design/frame_sender.sv */
module frame_sender #(
  parameter int FRAME_WIDTH = 4,
  parameter int FRAME_HEIGHT = 3,
  localparam int ADDR_W = (FRAME_WIDTH * FRAME_HEIGHT > 1) ?
                          $clog2(FRAME_WIDTH * FRAME_HEIGHT) : 1
) (
  input  logic                           clk,
  input  logic                           uart_reset,
  input  logic                           send_en,
  output logic [ADDR_W-1:0]              rd_addr,
  input  frame_pkg::rgb332_u             rd_data,
  input  logic                           tx_busy,
  output logic                           tx_start,
  output logic [uart_pkg::UART_DATA_W-1:0] tx_data,
  output logic                           send_done
);

  import uart_pkg::*;

  localparam logic [ADDR_W-1:0] LAST_PIX = ADDR_W'(FRAME_WIDTH * FRAME_HEIGHT - 1);

  // fetch, load, issue per byte, then drain the last one
  typedef enum logic [2:0] {
    PH_FETCH,
    PH_LOAD,
    PH_ISSUE,
    PH_DRAIN,
    PH_DONE
  } phase_e;

  phase_e      phase_q;
  logic [ADDR_W-1:0] pix_q;
  logic [1:0]  chan_q;

  assign rd_addr   = pix_q;
  assign tx_start  = (phase_q == PH_ISSUE) && !tx_busy;
  // last stop bit has ended
  assign send_done = (phase_q == PH_DRAIN) && !tx_busy;

  ////////////////////////////////////////////////////////////
  // pixel and channel sequencer
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (uart_reset || !send_en) begin
      phase_q <= PH_FETCH;
      pix_q   <= '0;
      chan_q  <= CH_GREEN;
    end else begin
      case (phase_q)
        // read data lands at this edge
        PH_FETCH: phase_q <= PH_LOAD;
        PH_LOAD:  phase_q <= PH_ISSUE;
        // hold until the serializer is free
        PH_ISSUE: begin
          if (!tx_busy) begin
            case (chan_q)
              CH_GREEN: chan_q <= CH_BLUE;
              CH_BLUE:  chan_q <= CH_RED;
              default:  chan_q <= CH_GREEN;
            endcase
            if (chan_q == CH_RED && pix_q == LAST_PIX) begin
              phase_q <= PH_DRAIN;
            end else begin
              phase_q <= PH_FETCH;
              if (chan_q == CH_RED) pix_q <= pix_q + ADDR_W'(1);
            end
          end
        end
        PH_DRAIN: begin
          if (!tx_busy) phase_q <= PH_DONE;
        end
        // wait here until the controller drops send_en
        default: phase_q <= PH_DONE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // byte build, channel bits at the top
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (phase_q == PH_LOAD) begin
      case (chan_q)
        CH_GREEN: tx_data <= {rd_data.fields.green, {(UART_DATA_W-3){1'b0}}};
        CH_BLUE:  tx_data <= {rd_data.fields.blue, {(UART_DATA_W-2){1'b0}}};
        default:  tx_data <= {rd_data.fields.red, {(UART_DATA_W-3){1'b0}}};
      endcase
    end
  end

endmodule

/* design/uart_tx.sv */
module uart_tx #(
  parameter int BAUD_DIV = 8
) (
  input  logic                             clk,
  input  logic                             uart_reset,
  input  logic                             tx_start,
  input  logic [uart_pkg::UART_DATA_W-1:0] tx_data,
  output logic                             txd,
  output logic                             tx_busy
);

  import uart_pkg::*;

  localparam int DIV_W = (BAUD_DIV > 1) ? $clog2(BAUD_DIV) : 1;
  localparam int BIT_W = $clog2(UART_FRAME_BITS);

  localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(BAUD_DIV - 1);
  localparam logic [BIT_W-1:0] BIT_LAST = BIT_W'(UART_FRAME_BITS - 1);

  // cycles within the current bit
  logic [DIV_W-1:0] div_q;
  // bit index within the frame, 0 is the start bit
  logic [BIT_W-1:0] bit_q;
  // data bits still to go, then the stop bit
  logic [UART_FRAME_BITS-2:0] shift_q;

  ////////////////////////////////////////////////////////////
  // control and line
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (uart_reset) begin
      tx_busy <= 1'b0;
      txd     <= 1'b1;
      div_q   <= '0;
      bit_q   <= '0;
    end else if (!tx_busy) begin
      if (tx_start) begin
        // start bit goes out next cycle
        tx_busy <= 1'b1;
        txd     <= 1'b0;
        div_q   <= '0;
        bit_q   <= '0;
      end
    end else if (div_q == DIV_LAST) begin
      div_q <= '0;
      if (bit_q == BIT_LAST) begin
        // stop bit done, line idles high
        tx_busy <= 1'b0;
        txd     <= 1'b1;
      end else begin
        bit_q <= bit_q + BIT_W'(1);
        txd   <= shift_q[0];
      end
    end else begin
      div_q <= div_q + DIV_W'(1);
    end
  end

  ////////////////////////////////////////////////////////////
  // data shifter
  ////////////////////////////////////////////////////////////

  // lsb first, stop bit rides in at the top
  always_ff @(posedge clk) begin
    if (!tx_busy && tx_start) begin
      shift_q <= {1'b1, tx_data};
    end else if (tx_busy && div_q == DIV_LAST) begin
      shift_q <= {1'b1, shift_q[UART_FRAME_BITS-2:1]};
    end
  end

endmodule

/* design/frame_uart_top.sv */
module frame_uart_top #(
  parameter int H_OFFSET = 2,
  parameter int V_OFFSET = 1,
  parameter int FRAME_WIDTH = 4,
  parameter int FRAME_HEIGHT = 3,
  parameter int BAUD_DIV = 8
) (
  input  logic                             clk,
  input  logic                             uart_reset,
  input  logic [frame_pkg::HCOUNT_W-1:0]   hcount,
  input  logic [frame_pkg::VCOUNT_W-1:0]   vcount,
  input  logic [frame_pkg::PIXEL_IN_W-1:0] pixel_in,
  input  logic                             store,
  input  logic                             send,
  output logic                             txd,
  output logic                             frame_ready,
  output logic                             sending
);

  import frame_pkg::*;
  import uart_pkg::*;

  localparam int ADDR_W = (FRAME_WIDTH * FRAME_HEIGHT > 1) ?
                          $clog2(FRAME_WIDTH * FRAME_HEIGHT) : 1;

  // controller to datapath
  logic              capture_en;
  logic              send_en;
  logic              frame_start;
  logic              frame_last;
  logic              send_done;
  // memory ports
  logic              wr_en;
  logic [ADDR_W-1:0] wr_addr;
  rgb332_u           wr_data;
  logic [ADDR_W-1:0] rd_addr;
  rgb332_u           rd_data;
  // serializer
  logic                   tx_start;
  logic [UART_DATA_W-1:0] tx_data;
  logic                   tx_busy;

  ////////////////////////////////////////////////////////////
  // control
  ////////////////////////////////////////////////////////////

  frame_ctrl u_ctrl (
    .clk         (clk),
    .uart_reset  (uart_reset),
    .store       (store),
    .send        (send),
    .frame_start (frame_start),
    .frame_last  (frame_last),
    .send_done   (send_done),
    .capture_en  (capture_en),
    .send_en     (send_en),
    .frame_ready (frame_ready),
    .sending     (sending)
  );

  ////////////////////////////////////////////////////////////
  // capture into the frame buffer
  ////////////////////////////////////////////////////////////

  capture_window #(
    .H_OFFSET     (H_OFFSET),
    .V_OFFSET     (V_OFFSET),
    .FRAME_WIDTH  (FRAME_WIDTH),
    .FRAME_HEIGHT (FRAME_HEIGHT)
  ) u_capture (
    .clk         (clk),
    .uart_reset  (uart_reset),
    .capture_en  (capture_en),
    .hcount      (hcount),
    .vcount      (vcount),
    .pixel_in    (pixel_in),
    .frame_start (frame_start),
    .frame_last  (frame_last),
    .wr_en       (wr_en),
    .wr_addr     (wr_addr),
    .wr_data     (wr_data)
  );

  frame_store #(
    .FRAME_WIDTH  (FRAME_WIDTH),
    .FRAME_HEIGHT (FRAME_HEIGHT)
  ) u_store (
    .clk     (clk),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  ////////////////////////////////////////////////////////////
  // send over the uart
  ////////////////////////////////////////////////////////////

  frame_sender #(
    .FRAME_WIDTH  (FRAME_WIDTH),
    .FRAME_HEIGHT (FRAME_HEIGHT)
  ) u_sender (
    .clk        (clk),
    .uart_reset (uart_reset),
    .send_en    (send_en),
    .rd_addr    (rd_addr),
    .rd_data    (rd_data),
    .tx_busy    (tx_busy),
    .tx_start   (tx_start),
    .tx_data    (tx_data),
    .send_done  (send_done)
  );

  uart_tx #(
    .BAUD_DIV (BAUD_DIV)
  ) u_uart_tx (
    .clk        (clk),
    .uart_reset (uart_reset),
    .tx_start   (tx_start),
    .tx_data    (tx_data),
    .txd        (txd),
    .tx_busy    (tx_busy)
  );

endmodule

/* sim/frame_checker.sv */
module frame_checker #(
  parameter int NUM_BYTES = 36,
  parameter int BIT_CYCLES = 8
) (
  input  logic                   clk,
  input  logic                   uart_reset,
  input  logic                   txd,
  input  logic                   frame_ready,
  input  logic                   sending,
  input  logic [NUM_BYTES*8-1:0] exp_bytes,
  output int                     byte_count,
  output int                     err_count
);

  // receiver state, one byte at a time
  logic       busy;
  int         cyc;
  int         idx;
  logic [7:0] data;

  initial begin
    busy       = 1'b0;
    cyc        = 0;
    idx        = 0;
    data       = '0;
    byte_count = 0;
    err_count  = 0;
  end

  ////////////////////////////////////////////////////////////
  // serial decode, sampled at each bit midpoint
  ////////////////////////////////////////////////////////////

  always @(posedge clk) begin : decode
    int         k;
    logic [7:0] exp;
    if (uart_reset) begin
      // partial byte is thrown away, next send starts at byte 0
      busy = 1'b0;
      cyc  = 0;
      idx  = 0;
    end else begin
      // frame must stay valid while it goes out
      if (sending && !frame_ready) begin
        err_count++;
        $display("sending is high while frame_ready is low at %0t", $time);
      end
      if (!busy) begin
        if (!txd) begin
          // first cycle of the start bit seen
          busy = 1'b1;
          cyc  = 1;
          if (!sending) begin
            err_count++;
            $display("start bit on txd while sending is low at %0t", $time);
          end
        end
      end else begin
        if (cyc % BIT_CYCLES == BIT_CYCLES / 2) begin
          k = cyc / BIT_CYCLES;
          if (k == 0) begin
            if (txd) begin
              err_count++;
              $display("start bit ended before its midpoint at %0t", $time);
              busy = 1'b0;
            end
          end else if (k <= 8) begin
            // lsb first
            data[k-1] = txd;
          end else begin
            if (!txd) begin
              err_count++;
              $display("FAILED txd_stop exp 1 got 0 at byte %0d", idx);
            end
            exp = exp_bytes[idx*8 +: 8];
            if (data !== exp) begin
              err_count++;
              $display("FAILED txd_byte[%0d] exp %h got %h", idx, exp, data);
            end
            byte_count++;
            idx  = (idx + 1) % NUM_BYTES;
            busy = 1'b0;
          end
        end
        cyc++;
      end
    end
  end

endmodule

/* sim/tb_top.sv */
module tb_top;

  localparam int H_TOTAL = 8;
  localparam int V_TOTAL = 6;
  localparam int H_OFF = 2;
  localparam int V_OFF = 1;
  localparam int WIDTH = 4;
  localparam int HEIGHT = 3;
  localparam int NUM_PIX = WIDTH * HEIGHT;
  localparam int NUM_BYTES = 3 * NUM_PIX;
  localparam int BIT_CYCLES = 8;
  localparam int SEND_CYCLES = NUM_BYTES * 10 * BIT_CYCLES;
  // three sends, four raster frames, margin
  localparam int TIMEOUT_CYCLES = 3 * SEND_CYCLES + 4 * H_TOTAL * V_TOTAL + 1168;

  logic        clk;
  logic        uart_reset;
  logic [10:0] hcount;
  logic [9:0]  vcount;
  logic [23:0] pixel_in;
  logic        store;
  logic        send;
  logic        txd;
  logic        frame_ready;
  logic        sending;

  // pixel then green blue and red bytes for each window pixel
  logic [23:0]            file_words [4*NUM_PIX];
  logic [NUM_BYTES*8-1:0] exp_bytes;
  logic [31:0]            rng;
  int                     cycles;
  int                     seq_errors;
  int                     byte_count;
  int                     chk_errors;

  frame_uart_top dut0 (
    .clk         (clk),
    .uart_reset  (uart_reset),
    .hcount      (hcount),
    .vcount      (vcount),
    .pixel_in    (pixel_in),
    .store       (store),
    .send        (send),
    .txd         (txd),
    .frame_ready (frame_ready),
    .sending     (sending)
  );

  frame_checker #(.NUM_BYTES(NUM_BYTES), .BIT_CYCLES(BIT_CYCLES)) chk0 (
    .clk         (clk),
    .uart_reset  (uart_reset),
    .txd         (txd),
    .frame_ready (frame_ready),
    .sending     (sending),
    .exp_bytes   (exp_bytes),
    .byte_count  (byte_count),
    .err_count   (chk_errors)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  always #50 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // raster with window pixels from the file and random pixels elsewhere
  ////////////////////////////////////////////////////////////

  always @(posedge clk) begin : raster
    int nh;
    int nv;
    nh = (hcount == H_TOTAL - 1) ? 0 : hcount + 1;
    nv = (hcount == H_TOTAL - 1) ? ((vcount == V_TOTAL - 1) ? 0 : vcount + 1) : vcount;
    hcount <= 11'(nh);
    vcount <= 10'(nv);
    rng = xorshift(rng);
    if (nh >= H_OFF && nh < H_OFF + WIDTH && nv >= V_OFF && nv < V_OFF + HEIGHT)
      pixel_in <= file_words[4 * ((nv - V_OFF) * WIDTH + nh - H_OFF)];
    else
      pixel_in <= rng[23:0];
  end

  // run limit
  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  task automatic store_request();
    @(posedge clk);
    store <= 1'b1;
    @(posedge clk);
    store <= 1'b0;
  endtask

  task automatic send_request();
    @(posedge clk);
    send <= 1'b1;
    @(posedge clk);
    send <= 1'b0;
  endtask

  task automatic expect_level(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      seq_errors++;
      $display("FAILED %s exp %h got %h at %0t", name, exp, got, $time);
    end
  endtask

  // send then wait for sending to drop
  task automatic run_send(input int expect_total);
    int n;
    send_request();
    n = 0;
    @(negedge clk);
    expect_level("sending", sending, 1'b1);
    while (txd && n < 4) begin
      @(negedge clk);
      n++;
    end
    if (txd) begin
      seq_errors++;
      $display("no start bit within 4 cycles of send");
    end
    n = 0;
    while (sending && n < SEND_CYCLES + 200) begin
      @(negedge clk);
      n++;
    end
    if (sending) begin
      seq_errors++;
      $display("sending did not fall after a full frame send");
    end
    if (byte_count != expect_total) begin
      seq_errors++;
      $display("FAILED byte_count exp %h got %h", expect_total, byte_count);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin : sequence_main
    int n;
    int m;
    clk        = 1'b0;
    uart_reset = 1'b1;
    hcount     = '0;
    vcount     = '0;
    pixel_in   = '0;
    store      = 1'b0;
    send       = 1'b0;
    rng        = 32'hd0c00b9d;
    cycles     = 0;
    seq_errors = 0;
    $readmemh("sim/frame_input.txt", file_words);
    for (int i = 0; i < NUM_PIX; i++) begin
      for (int c = 0; c < 3; c++) begin
        exp_bytes[(3*i + c)*8 +: 8] = file_words[4*i + 1 + c][7:0];
      end
    end

    repeat (3) @(posedge clk);
    uart_reset <= 1'b0;
    @(negedge clk);
    expect_level("txd", txd, 1'b1);
    expect_level("frame_ready", frame_ready, 1'b0);
    expect_level("sending", sending, 1'b0);

    // store then a second store in the middle of the window
    store_request();
    n = 2;
    while (vcount != 2 && n < H_TOTAL * V_TOTAL) begin
      @(negedge clk);
      n++;
    end
    store_request();
    n += 2;
    // a restarted capture would only finish in the next raster frame
    m = 2;
    while (!frame_ready && m < H_TOTAL * V_TOTAL) begin
      @(negedge clk);
      n++;
      m++;
    end
    if (!frame_ready) begin
      seq_errors++;
      $display("frame_ready did not rise in the raster frame of the second store");
    end
    if (n > 2 * H_TOTAL * V_TOTAL) begin
      seq_errors++;
      $display("frame_ready did not rise within two raster frames");
    end

    run_send(NUM_BYTES);

    // repeat send with a store pulse while it runs
    fork
      run_send(2 * NUM_BYTES);
      begin
        repeat (300) @(posedge clk);
        store_request();
      end
    join
    @(negedge clk);
    expect_level("frame_ready", frame_ready, 1'b1);

    // reset in the middle of a third send
    send_request();
    n = 0;
    while (byte_count < 2 * NUM_BYTES + 5 && n < SEND_CYCLES) begin
      @(negedge clk);
      n++;
    end
    while (txd && n < SEND_CYCLES) begin
      @(negedge clk);
      n++;
    end
    repeat (20) @(negedge clk);
    if (!sending || byte_count < 2 * NUM_BYTES + 5) begin
      seq_errors++;
      $display("third send was not under way when the reset came");
    end
    @(posedge clk);
    uart_reset <= 1'b1;
    @(posedge clk);
    @(negedge clk);
    expect_level("txd", txd, 1'b1);
    expect_level("frame_ready", frame_ready, 1'b0);
    expect_level("sending", sending, 1'b0);
    repeat (2) @(posedge clk);
    uart_reset <= 1'b0;
    // line must stay idle with no new requests
    repeat (300) begin
      @(negedge clk);
      if (!txd || sending) begin
        seq_errors++;
        $display("serial activity after reset without a new store and send");
      end
    end

    $display("errors: sequence %0d, checker %0d, bytes received %0d",
             seq_errors, chk_errors, byte_count);
    if (seq_errors == 0 && chk_errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* sim/frame_input.txt */
// one window pixel per line, in raster order
// pixel_in[23:0]  green_byte  blue_byte  red_byte
ff0000 00 00 e0
00ff00 e0 00 00
0000ff 00 c0 00
ffffff e0 c0 e0
123456 20 40 00
a5c3e7 c0 c0 a0
7f80c1 80 c0 60
3c9a4d 80 40 20
e01f60 00 40 e0
5bd28e c0 80 40
9966cc 60 c0 80
2468ac 60 80 20

/* tb.f */
design/frame_pkg.sv
design/uart_pkg.sv
design/frame_ctrl.sv
design/capture_window.sv
design/frame_store.sv
design/frame_sender.sv
design/uart_tx.sv
design/frame_uart_top.sv
sim/frame_checker.sv
sim/tb_top.sv

/* Makefile */
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run tb_top"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --top-module tb_top -f tb.f -o sim_tb
	./obj_dir/sim_tb | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then exit 1; fi
	@grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
